// ==== hdl/cart_ascii8.sv ====
`timescale 1ns/1ps

module cart_ascii8 (
   input  logic                   clk,
   input  logic                   reset,
   input  msx_pkg::cpu_bus_t      bus,
   input  logic                   cs,
   input  logic [15:0]            rom_size,
   output logic [msx_pkg::RAM_ADDR_W-1:0] mem_addr,
   output logic                   unmapped
);

   logic [msx_pkg::BANK_W-1:0]     bank [4];
   logic [msx_pkg::BANK_W-1:0]     cur_bank;
   logic [1:0]                     rd_idx;
   logic                           bank_wr;
   logic                           in_range;
   logic [msx_pkg::RAM_ADDR_W-1:0] rom_mask;

   // bank switch window 6000-7FFF
   assign bank_wr = cs & bus.mreq & bus.wr & (bus.addr[15:13] == 3'b011);

   always_ff @(posedge clk) begin
      if (reset) begin
         bank[0] <= '0;
         bank[1] <= '0;
         bank[2] <= '0;
         bank[3] <= '0;
      end else if (bank_wr) begin
         bank[bus.addr[12:11]] <= bus.dout;
      end
   end

   // 8 KB pages 4000-BFFF map to banks 0..3
   assign rd_idx   = 2'(bus.addr[15:13] - 3'd2);
   assign cur_bank = bank[rd_idx];
   assign in_range = (bus.addr[15:14] == 2'b01) | (bus.addr[15:14] == 2'b10);

   // wrap at image size
   assign rom_mask = (msx_pkg::RAM_ADDR_W'(rom_size) << 14) - 1'b1;

   assign mem_addr = msx_pkg::RAM_ADDR_W'({cur_bank, bus.addr[12:0]}) & rom_mask;
   assign unmapped = cs & ~in_range;

endmodule

// ==== hdl/cart_konami.sv ====
`timescale 1ns/1ps

module cart_konami (
   input  logic                   clk,
   input  logic                   reset,
   input  msx_pkg::cpu_bus_t      bus,
   input  logic                   cs,
   input  logic [15:0]            rom_size,
   output logic [msx_pkg::RAM_ADDR_W-1:0] mem_addr,
   output logic                   unmapped
);

   // bank 0 never written, stays at 0
   logic [msx_pkg::BANK_W-1:0]     bank [4];
   logic [msx_pkg::BANK_W-1:0]     cur_bank;
   logic [1:0]                     idx;
   logic                           bank_wr;
   logic                           in_range;
   logic [msx_pkg::RAM_ADDR_W-1:0] rom_mask;

   assign idx = 2'(bus.addr[15:13] - 3'd2);

   // switch windows 6000, 8000 and A000
   assign bank_wr = cs & bus.mreq & bus.wr &
                    (bus.addr[15:13] inside {3'd3, 3'd4, 3'd5});

   always_ff @(posedge clk) begin
      if (reset) begin
         bank[0] <= 8'd0;
         bank[1] <= 8'd1;
         bank[2] <= 8'd2;
         bank[3] <= 8'd3;
      end else if (bank_wr) begin
         bank[idx] <= bus.dout;
      end
   end

   assign cur_bank = bank[idx];
   assign in_range = (bus.addr[15:14] == 2'b01) | (bus.addr[15:14] == 2'b10);

   assign rom_mask = (msx_pkg::RAM_ADDR_W'(rom_size) << 14) - 1'b1;

   // same 8 KB layout as ascii8
   assign mem_addr = msx_pkg::RAM_ADDR_W'({cur_bank, bus.addr[12:0]}) & rom_mask;
   assign unmapped = cs & ~in_range;

endmodule

// ==== hdl/msx_pkg.sv ====
package msx_pkg;

   // external memory address and bank register widths
   localparam int RAM_ADDR_W = 27;
   localparam int BANK_W     = 8;

   // one cycle of z80 bus state
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  dout;
      logic        wr;
      logic        rd;
      logic        mreq;
      logic        iorq;
      logic        m1;
   } cpu_bus_t;

   // address translation kind of a 16 KB block
   typedef enum logic [3:0] {
      MAPPER_UNUSED = 4'd0,
      MAPPER_NONE   = 4'd1,
      MAPPER_LINEAR = 4'd2,
      MAPPER_ASCII8 = 4'd3,
      MAPPER_KONAMI = 4'd4,
      MAPPER_RAM    = 4'd5
   } mapper_t;

   // layout entry for slot / subslot / block
   typedef struct packed {
      logic [3:0] ref_ram;
      // in 16 KB units
      logic [1:0] offset_ram;
      mapper_t    mapper;
   } block_t;

   // memory region descriptor
   typedef struct packed {
      logic [RAM_ADDR_W-1:0] addr;
      // size in 16 KB units
      logic [15:0]           size;
      logic                  ro;
   } lookup_ram_t;

endpackage

// ==== hdl/msx_slots.sv ====
`timescale 1ns/1ps

module msx_slots #(
   parameter int RAM_BLOCK_BITS = 8
) (
   input  logic                   clk,
   input  logic                   reset,
   input  msx_pkg::cpu_bus_t      bus,
   input  logic [1:0]             active_slot,
   input  logic [3:0]             expander_en,
   input  msx_pkg::block_t        slot_layout [64],
   input  msx_pkg::lookup_ram_t   lookup_ram [16],
   output logic [msx_pkg::RAM_ADDR_W-1:0] ram_addr,
   output logic [7:0]             ram_din,
   output logic                   ram_rnw,
   output logic                   ram_ce,
   input  logic [7:0]             ram_dout,
   output logic [7:0]             cpu_din
);

   localparam int AW = msx_pkg::RAM_ADDR_W;

   logic [1:0]       subslot;
   logic             exp_access;
   logic [7:0]       exp_dout;
   logic [AW-1:0]    base;
   logic [15:0]      size;
   logic             ro;
   logic [1:0]       offset_ram;
   msx_pkg::mapper_t mapper;

   slot_expander expander0 (
      .clk         (clk),
      .reset       (reset),
      .bus         (bus),
      .active_slot (active_slot),
      .expander_en (expander_en),
      .subslot     (subslot),
      .exp_access  (exp_access),
      .exp_dout    (exp_dout)
   );

   slot_decoder decoder0 (
      .slot_layout (slot_layout),
      .lookup_ram  (lookup_ram),
      .active_slot (active_slot),
      .subslot     (subslot),
      .block       (bus.addr[15:14]),
      .base        (base),
      .size        (size),
      .ro          (ro),
      .offset_ram  (offset_ram),
      .mapper      (mapper)
   );

   // cartridge mappers, one select each
   logic [AW-1:0] ascii8_addr;
   logic [AW-1:0] konami_addr;
   logic          ascii8_unmapped;
   logic          konami_unmapped;

   cart_ascii8 ascii8 (
      .clk      (clk),
      .reset    (reset),
      .bus      (bus),
      .cs       (mapper == msx_pkg::MAPPER_ASCII8),
      .rom_size (size),
      .mem_addr (ascii8_addr),
      .unmapped (ascii8_unmapped)
   );

   cart_konami konami (
      .clk      (clk),
      .reset    (reset),
      .bus      (bus),
      .cs       (mapper == msx_pkg::MAPPER_KONAMI),
      .rom_size (size),
      .mem_addr (konami_addr),
      .unmapped (konami_unmapped)
   );

   logic [AW-1:0] ram_page_addr;
   logic [7:0]    mapper_io_dout;

   ram_mapper #(
      .RAM_BLOCK_BITS (RAM_BLOCK_BITS)
   ) msx2_ram (
      .clk       (clk),
      .reset     (reset),
      .bus       (bus),
      .page_addr (ram_page_addr),
      .io_dout   (mapper_io_dout)
   );

   // offset within the block's memory region
   logic [AW-1:0] none_addr;
   logic [AW-1:0] linear_addr;
   logic [AW-1:0] mapper_addr;

   assign none_addr   = (AW'(offset_ram) << 14) + AW'(bus.addr[13:0]);
   assign linear_addr = AW'(bus.addr) & ((AW'(size) << 14) - 1'b1);

   always_comb begin
      case (mapper)
         msx_pkg::MAPPER_NONE:   mapper_addr = none_addr;
         msx_pkg::MAPPER_LINEAR: mapper_addr = linear_addr;
         msx_pkg::MAPPER_ASCII8: mapper_addr = ascii8_addr;
         msx_pkg::MAPPER_KONAMI: mapper_addr = konami_addr;
         msx_pkg::MAPPER_RAM:    mapper_addr = ram_page_addr;
         default:                mapper_addr = '0;
      endcase
   end

   assign ram_addr = base + mapper_addr;

   logic mem_unmapped;
   logic mem_mapped;

   assign mem_unmapped = ascii8_unmapped | konami_unmapped;

   // memory cycle that reaches external memory
   assign mem_mapped = bus.mreq & (mapper != msx_pkg::MAPPER_UNUSED) &
                       ~mem_unmapped & ~exp_access;

   assign ram_ce  = mem_mapped & (bus.rd | (bus.wr & ~ro));
   assign ram_rnw = bus.rd;
   assign ram_din = bus.dout;

   // idle sources sit at FF
   assign cpu_din = exp_dout
                  & mapper_io_dout
                  & ((mem_mapped & bus.rd) ? ram_dout : 8'hFF);

endmodule

// ==== hdl/ram_mapper.sv ====
`timescale 1ns/1ps

module ram_mapper #(
   parameter int RAM_BLOCK_BITS = 8
) (
   input  logic                   clk,
   input  logic                   reset,
   input  msx_pkg::cpu_bus_t      bus,
   output logic [msx_pkg::RAM_ADDR_W-1:0] page_addr,
   output logic [7:0]             io_dout
);

   // page registers for FC, FD, FE, FF
   logic [RAM_BLOCK_BITS-1:0] page [4];
   logic [RAM_BLOCK_BITS-1:0] io_page;
   logic [RAM_BLOCK_BITS-1:0] mem_page;
   logic                      io_hit;

   // ports FC-FF, m1 low excludes interrupt acknowledge
   assign io_hit = bus.iorq & ~bus.m1 & (bus.addr[7:2] == 6'b111111);

   always_ff @(posedge clk) begin
      if (reset) begin
         page[0] <= RAM_BLOCK_BITS'(3);
         page[1] <= RAM_BLOCK_BITS'(2);
         page[2] <= RAM_BLOCK_BITS'(1);
         page[3] <= RAM_BLOCK_BITS'(0);
      end else if (io_hit & bus.wr) begin
         page[bus.addr[1:0]] <= bus.dout[RAM_BLOCK_BITS-1:0];
      end
   end

   assign io_page = page[bus.addr[1:0]];

   // unused upper bits read as 1
   assign io_dout = (io_hit & bus.rd) ? ~(8'(~io_page)) : 8'hFF;

   assign mem_page  = page[bus.addr[15:14]];
   assign page_addr = (msx_pkg::RAM_ADDR_W'(mem_page) << 14) |
                      msx_pkg::RAM_ADDR_W'(bus.addr[13:0]);

endmodule

// ==== hdl/slot_decoder.sv ====
`timescale 1ns/1ps

module slot_decoder (
   input  msx_pkg::block_t        slot_layout [64],
   input  msx_pkg::lookup_ram_t   lookup_ram [16],
   input  logic [1:0]             active_slot,
   input  logic [1:0]             subslot,
   input  logic [1:0]             block,
   output logic [msx_pkg::RAM_ADDR_W-1:0] base,
   output logic [15:0]            size,
   output logic                   ro,
   output logic [1:0]             offset_ram,
   output msx_pkg::mapper_t       mapper
);

   logic [5:0]           layout_id;
   msx_pkg::block_t      entry;
   msx_pkg::lookup_ram_t desc;

   // slot, subslot, block
   assign layout_id = {active_slot, subslot, block};
   assign entry     = slot_layout[layout_id];

   // descriptor chosen by the entry
   assign desc = lookup_ram[entry.ref_ram];

   assign base       = desc.addr;
   assign size       = desc.size;
   assign ro         = desc.ro;
   assign offset_ram = entry.offset_ram;
   assign mapper     = entry.mapper;

endmodule

// ==== hdl/slot_expander.sv ====
`timescale 1ns/1ps

module slot_expander (
   input  logic                clk,
   input  logic                reset,
   input  msx_pkg::cpu_bus_t   bus,
   input  logic [1:0]          active_slot,
   input  logic [3:0]          expander_en,
   output logic [1:0]          subslot,
   output logic                exp_access,
   output logic [7:0]          exp_dout
);

   // one secondary slot register per primary slot
   logic [7:0] exp_reg [4];
   logic [7:0] cur_reg;
   logic [1:0] block;

   assign cur_reg = exp_reg[active_slot];
   assign block   = bus.addr[15:14];

   // FFFF only answers in an expanded slot
   assign exp_access = (bus.addr == 16'hFFFF) & bus.mreq & expander_en[active_slot];

   always_ff @(posedge clk) begin
      if (reset) begin
         exp_reg[0] <= 8'h00;
         exp_reg[1] <= 8'h00;
         exp_reg[2] <= 8'h00;
         exp_reg[3] <= 8'h00;
      end else if (exp_access & bus.wr) begin
         exp_reg[active_slot] <= bus.dout;
      end
   end

   // register reads back inverted, as on real hardware
   assign exp_dout = (exp_access & bus.rd) ? ~cur_reg : 8'hFF;

   // two bits per 16 KB block
   assign subslot = expander_en[active_slot] ? cur_reg[2*block +: 2] : 2'd0;

endmodule

// ==== msx_slots.f ====
+incdir+include
hdl/msx_pkg.sv
hdl/slot_expander.sv
hdl/slot_decoder.sv
hdl/cart_ascii8.sv
hdl/cart_konami.sv
hdl/ram_mapper.sv
hdl/msx_slots.sv
test/tb_msx_slots.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
   --top-module tb_msx_slots \
   -f msx_slots.f

./obj_dir/Vtb_msx_slots

// ==== include/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// galois lfsr, one step per random bit
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic model_unmapped(input logic [15:0] addr,
                                        input msx_pkg::mapper_t mapper);
   logic cart;
   cart = (mapper == msx_pkg::MAPPER_ASCII8) | (mapper == msx_pkg::MAPPER_KONAMI);
   return cart & ~(addr[15:14] inside {2'b01, 2'b10});
endfunction

// expected ram_addr from shadow banks and pages
function automatic logic [26:0] model_addr(input msx_pkg::cpu_bus_t bus,
                                           input msx_pkg::block_t blk,
                                           input msx_pkg::lookup_ram_t desc,
                                           input logic [3:0][7:0] a8_bank,
                                           input logic [3:0][7:0] kn_bank,
                                           input logic [3:0][7:0] pages);
   logic [26:0] mask;
   logic [1:0]  idx;
   logic [26:0] ofs;
   mask = (27'(desc.size) << 14) - 27'd1;
   idx  = 2'(bus.addr[15:13] - 3'd2);
   case (blk.mapper)
      msx_pkg::MAPPER_NONE:   ofs = (27'(blk.offset_ram) << 14) + 27'(bus.addr[13:0]);
      msx_pkg::MAPPER_LINEAR: ofs = 27'(bus.addr) & mask;
      msx_pkg::MAPPER_ASCII8: ofs = 27'({a8_bank[idx], bus.addr[12:0]}) & mask;
      msx_pkg::MAPPER_KONAMI: ofs = 27'({kn_bank[idx], bus.addr[12:0]}) & mask;
      msx_pkg::MAPPER_RAM:    ofs = 27'({pages[bus.addr[15:14]], bus.addr[13:0]});
      default:                ofs = 27'd0;
   endcase
   return desc.addr + ofs;
endfunction

function automatic logic model_ce(input msx_pkg::cpu_bus_t bus,
                                  input msx_pkg::block_t blk,
                                  input msx_pkg::lookup_ram_t desc,
                                  input logic exp_acc);
   return bus.mreq & (bus.rd | (bus.wr & ~desc.ro)) &
          (blk.mapper != msx_pkg::MAPPER_UNUSED) &
          ~model_unmapped(bus.addr, blk.mapper) & ~exp_acc;
endfunction

// read merge with an 8 bit mapper page width
function automatic logic [7:0] model_din(input msx_pkg::cpu_bus_t bus,
                                         input msx_pkg::block_t blk,
                                         input logic exp_acc,
                                         input logic [7:0] exp_reg,
                                         input logic [3:0][7:0] pages,
                                         input logic [7:0] ram_dout);
   logic [7:0] d;
   d = 8'hFF;
   if (exp_acc & bus.rd)
      d = d & ~exp_reg;
   if (bus.iorq & ~bus.m1 & bus.rd & (bus.addr[7:2] == 6'b111111))
      d = d & pages[bus.addr[1:0]];
   if (bus.mreq & bus.rd & (blk.mapper != msx_pkg::MAPPER_UNUSED) &
       ~model_unmapped(bus.addr, blk.mapper) & ~exp_acc)
      d = d & ram_dout;
   return d;
endfunction

`endif

// ==== test/tb_msx_slots.sv ====
`timescale 1ns/1ps

module tb_msx_slots;

`include "tb_model.svh"

   localparam int RESET_CYCLES = 2;
   localparam int N_EXP        = 8;
   localparam int N_MAP        = 64;
   localparam int N_WR         = 8;
   localparam int N_RD         = 40;
   // reset, reset check, expander, none/linear, ascii8, konami, ram mapper
   localparam int TOTAL_CYCLES = RESET_CYCLES + 8 + 7 * N_EXP + N_MAP +
                                 (N_WR + N_RD) + (1 + N_WR + N_RD) + (N_WR + 4 + N_RD) + 1;
   localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 50) * 8;

   logic                 clk = 1'b0;
   logic                 reset;
   msx_pkg::cpu_bus_t    bus;
   logic [1:0]           active_slot;
   logic [3:0]           expander_en;
   msx_pkg::block_t      slot_layout [64];
   msx_pkg::lookup_ram_t lookup_ram [16];
   logic [26:0]          ram_addr;
   logic [7:0]           ram_din;
   logic                 ram_rnw;
   logic                 ram_ce;
   logic [7:0]           ram_dout;
   logic [7:0]           cpu_din;

   // shadow copies of the DUT registers
   logic [3:0][7:0]      exp_sh;
   logic [3:0][7:0]      a8_sh;
   logic [3:0][7:0]      kn_sh;
   logic [3:0][7:0]      page_sh;
   logic [31:0]          lfsr;
   string                test_name;

   msx_slots #(
      .RAM_BLOCK_BITS (8)
   ) dut0 (
      .clk         (clk),
      .reset       (reset),
      .bus         (bus),
      .active_slot (active_slot),
      .expander_en (expander_en),
      .slot_layout (slot_layout),
      .lookup_ram  (lookup_ram),
      .ram_addr    (ram_addr),
      .ram_din     (ram_din),
      .ram_rnw     (ram_rnw),
      .ram_ce      (ram_ce),
      .ram_dout    (ram_dout),
      .cpu_din     (cpu_din)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic check(input string what, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         $display("ERR %s %s expected %0h actual %0h", test_name, what, expected, actual);
         $display("TB FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // one bus cycle, driven on the falling edge and held until the next one
   task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data,
                            input logic wr, input logic rd, input logic mem);
      msx_pkg::cpu_bus_t b;
      b.addr = addr;
      b.dout = data;
      b.wr   = wr;
      b.rd   = rd;
      b.mreq = mem;
      b.iorq = ~mem;
      b.m1   = 1'b0;
      bus      = b;
      ram_dout = 8'(rand_bits(8));
      @(negedge clk);
   endtask

   task automatic idle_cycle();
      bus = '0;
      @(negedge clk);
   endtask

   task automatic randomize_descs();
      logic [31:0] r;
      for (int j = 0; j < 16; j++) begin
         r = rand_bits(5);
         lookup_ram[j].addr = 27'(rand_bits(27));
         lookup_ram[j].size = 16'(r[3:0]) + 16'd1;
         lookup_ram[j].ro   = r[4];
      end
   endtask

   // every entry gets kind a or b at random
   task automatic fill_layout(input msx_pkg::mapper_t a, input msx_pkg::mapper_t b);
      logic [31:0] r;
      for (int j = 0; j < 64; j++) begin
         r = rand_bits(7);
         slot_layout[j].ref_ram    = r[3:0];
         slot_layout[j].offset_ram = r[5:4];
         slot_layout[j].mapper     = r[6] ? b : a;
      end
   endtask

   // compare before the register update, then advance the shadows
   always @(posedge clk) begin
      logic                 exp_acc;
      logic [1:0]           blk_no;
      logic [7:0]           cur_exp;
      logic [1:0]           sub;
      msx_pkg::block_t      blk;
      msx_pkg::lookup_ram_t desc;
      if (reset) begin
         exp_sh  = '0;
         a8_sh   = '0;
         kn_sh   = {8'd3, 8'd2, 8'd1, 8'd0};
         page_sh = {8'd0, 8'd1, 8'd2, 8'd3};
      end else begin
         blk_no  = bus.addr[15:14];
         cur_exp = exp_sh[active_slot];
         sub     = expander_en[active_slot] ? cur_exp[{blk_no, 1'b0} +: 2] : 2'd0;
         exp_acc = (bus.addr == 16'hFFFF) & bus.mreq & expander_en[active_slot];
         blk     = slot_layout[{active_slot, sub, blk_no}];
         desc    = lookup_ram[blk.ref_ram];
         check("ram_ce", 32'(model_ce(bus, blk, desc, exp_acc)), 32'(ram_ce));
         check("ram_addr", 32'(model_addr(bus, blk, desc, a8_sh, kn_sh, page_sh)),
               32'(ram_addr));
         check("cpu_din", 32'(model_din(bus, blk, exp_acc, cur_exp, page_sh, ram_dout)),
               32'(cpu_din));
         check("ram_rnw", 32'(bus.rd), 32'(ram_rnw));
         check("ram_din", 32'(bus.dout), 32'(ram_din));
         if (exp_acc & bus.wr)
            exp_sh[active_slot] = bus.dout;
         if ((blk.mapper == msx_pkg::MAPPER_ASCII8) & bus.mreq & bus.wr &
             (bus.addr[15:13] == 3'd3))
            a8_sh[bus.addr[12:11]] = bus.dout;
         // bank 0 window 4000-5FFF is not writable
         if ((blk.mapper == msx_pkg::MAPPER_KONAMI) & bus.mreq & bus.wr &
             (bus.addr[15:13] inside {3'd3, 3'd4, 3'd5}))
            kn_sh[2'(bus.addr[15:13] - 3'd2)] = bus.dout;
         if (bus.iorq & ~bus.m1 & bus.wr & (bus.addr[7:2] == 6'b111111))
            page_sh[bus.addr[1:0]] = bus.dout;
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("TB FAILED");
      $fatal(1, "simulation timed out");
   end

   initial begin
      logic [31:0] r;
      lfsr        = 32'd7;
      reset       = 1'b1;
      bus         = '0;
      active_slot = 2'd0;
      expander_en = 4'd0;
      ram_dout    = 8'h00;
      test_name   = "reset";
      randomize_descs();
      fill_layout(msx_pkg::MAPPER_UNUSED, msx_pkg::MAPPER_UNUSED);
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;

      // mreq low, then the mapper ports with their reset pages
      repeat (4) idle_cycle();
      for (int i = 0; i < 4; i++)
         bus_cycle(16'h00FC + 16'(i), 8'h00, 1'b0, 1'b1, 1'b0);

      test_name   = "expander";
      expander_en = 4'b1010;
      fill_layout(msx_pkg::MAPPER_NONE, msx_pkg::MAPPER_NONE);
      for (int i = 0; i < N_EXP; i++) begin
         r           = rand_bits(1);
         active_slot = {r[0], 1'b1};
         bus_cycle(16'hFFFF, 8'(rand_bits(8)), 1'b1, 1'b0, 1'b1);
         bus_cycle(16'hFFFF, 8'h00, 1'b0, 1'b1, 1'b1);
         for (int b = 0; b < 4; b++)
            bus_cycle({2'(b), 14'(rand_bits(14))}, 8'h00, 1'b0, 1'b1, 1'b1);
         // same slot number with no expander is plain memory at FFFF
         active_slot = {r[0], 1'b0};
         bus_cycle(16'hFFFF, 8'h00, 1'b0, 1'b1, 1'b1);
      end

      test_name = "none_linear";
      for (int i = 0; i < N_MAP; i++) begin
         if (i % 16 == 0) begin
            randomize_descs();
            fill_layout(msx_pkg::MAPPER_NONE, msx_pkg::MAPPER_LINEAR);
         end
         r           = rand_bits(7);
         active_slot = r[1:0];
         expander_en = r[5:2];
         bus_cycle(16'(rand_bits(16)), 8'(rand_bits(8)), r[6], ~r[6], 1'b1);
      end

      test_name   = "ascii8";
      expander_en = 4'd0;
      active_slot = 2'(rand_bits(2));
      randomize_descs();
      fill_layout(msx_pkg::MAPPER_ASCII8, msx_pkg::MAPPER_ASCII8);
      for (int i = 0; i < N_WR; i++)
         bus_cycle(16'h6000 | 16'(rand_bits(13)), 8'(rand_bits(8)), 1'b1, 1'b0, 1'b1);
      for (int i = 0; i < N_RD; i++)
         bus_cycle(16'(rand_bits(16)), 8'h00, 1'b0, 1'b1, 1'b1);

      test_name = "konami";
      fill_layout(msx_pkg::MAPPER_KONAMI, msx_pkg::MAPPER_KONAMI);
      bus_cycle(16'h4000, 8'(rand_bits(8)), 1'b1, 1'b0, 1'b1);
      for (int i = 0; i < N_WR; i++)
         bus_cycle(16'h4000 + 16'(rand_bits(15)), 8'(rand_bits(8)), 1'b1, 1'b0, 1'b1);
      for (int i = 0; i < N_RD; i++)
         bus_cycle(16'(rand_bits(16)), 8'h00, 1'b0, 1'b1, 1'b1);

      test_name = "ram_mapper";
      fill_layout(msx_pkg::MAPPER_RAM, msx_pkg::MAPPER_RAM);
      for (int i = 0; i < N_WR; i++)
         bus_cycle({8'(rand_bits(8)), 6'b111111, 2'(rand_bits(2))}, 8'(rand_bits(8)),
                   1'b1, 1'b0, 1'b0);
      for (int i = 0; i < 4; i++)
         bus_cycle(16'h00FC + 16'(i), 8'h00, 1'b0, 1'b1, 1'b0);
      for (int i = 0; i < N_RD; i++) begin
         r = rand_bits(1);
         bus_cycle(16'(rand_bits(16)), 8'(rand_bits(8)), r[0], ~r[0], 1'b1);
      end

      idle_cycle();
      $display("TB PASSED");
      $finish;
   end

endmodule
